//--- vlog.f
+incdir+include
design/linkPkg.sv
design/cmdPkg.sv
design/msgQueue.sv
design/serialRx.sv
design/serialTx.sv
design/msgSender.sv
design/cmdHandler.sv
design/debugTop.sv
test/debugChecker.sv
test/debugTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module debugTb -o debugSim
output=$(./obj_dir/debugSim)
echo "$output"

if grep -q "Test completed successfully" <<< "$output"; then
    exit 0
fi
exit 1

//--- test/debugTb.sv
`timescale 1ns/1ps
`include "debugLink_settings.svh"

module debugTb;
    localparam int ClkHalf = 50;
    localparam int Seed = 91661;

    // Watchdog budget per message covers nops, header, long payload and trailing nop,
    // a gap, and the longest reply with a few frames of latency
    localparam int MsgCount = 49;
    localparam int MaxMsgBits = 8 * (3 + 2 + 9 + 1);
    localparam int MaxGap = 6;
    localparam int MaxReplyBits = 8 * (2 + 16 + 4);
    localparam int FillCycles = 5 + `MEM_WORDS + 4;
    localparam int Margin = 2;
    localparam int WatchdogCycles =
        (FillCycles + MsgCount * (MaxMsgBits + MaxGap + MaxReplyBits)) * Margin;

    logic clk = 1'b0;
    logic rstN;
    logic cs;
    logic di;
    logic dout;
    logic [3:0] led;

    logic [7:0] payload [16];
    logic [3:0] expLed;

    always #ClkHalf clk = ~clk;

    debugTop debugTop_inst (
        .clk(clk), .rstN(rstN), .cs(cs), .di(di), .dout(dout), .led(led)
    );

    debugChecker checkerInst (
        .clk(clk), .rstN(rstN), .cs(cs), .dout(dout), .led(led)
    );

    // ==========================================================================
    // Serial host
    // ==========================================================================
    task automatic driveBit(input logic b);
        @(posedge clk);
        cs <= 1'b1;
        di <= b;
    endtask

    task automatic shiftByte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            driveBit(b[i]);
        end
    endtask

    task automatic idleGap();
        int n;
        n = 1 + int'($urandom % MaxGap);
        repeat (n) begin
            @(posedge clk);
            cs <= 1'b0;
            di <= 1'b0;
        end
    endtask

    task automatic maybeGap();
        if ($urandom % 2 == 0) begin
            idleGap();
        end
    endtask

    task automatic randomizePayload();
        foreach (payload[i]) begin
            payload[i] = 8'($urandom);
        end
    endtask

    task automatic writeMsg(input logic [7:0] msgType, input int len, input int nops);
        repeat (nops) shiftByte(8'h00);
        shiftByte(msgType);
        shiftByte(8'(len));
        for (int i = 0; i < len; i++) begin
            shiftByte(payload[i]);
        end
        // Trailing nop lets the last byte land before cs may fall
        shiftByte(8'h00);
    endtask

    // Sends only the first keepBits of a message, then drops cs
    task automatic cutMsg(input logic [7:0] msgType, input int len, input int keepBits);
        logic [7:0] bytes [$];
        int sent;
        bytes.push_back(msgType);
        bytes.push_back(8'(len));
        for (int i = 0; i < len; i++) begin
            bytes.push_back(payload[i]);
        end
        sent = 0;
        foreach (bytes[i]) begin
            for (int j = 7; j >= 0; j--) begin
                if (sent < keepBits) begin
                    driveBit(bytes[i][j]);
                    sent++;
                end
            end
        end
        idleGap();
    endtask

    // ==========================================================================
    // Messages and their expected effects
    // ==========================================================================
    task automatic setLed(input int len, input int nops);
        randomizePayload();
        writeMsg(8'(linkPkg::SET_LED), len, nops);
        expLed = payload[0][3:0];
        maybeGap();
    endtask

    task automatic readMem(input int len, input int nops);
        logic [6:0] wordAddr;
        logic [15:0] word;
        int count;
        randomizePayload();
        payload[1] = 8'(1 + $urandom % 8);
        count = int'(payload[1]);
        checkerInst.expectByte(8'(linkPkg::READ_MEM));
        checkerInst.expectByte(8'(2 * count));
        // Each word holds its own address, which wraps at the memory size
        for (int i = 0; i < count; i++) begin
            wordAddr = payload[0][6:0] + 7'(i);
            word = {9'd0, wordAddr};
            checkerInst.expectByte(word[15:8]);
            checkerInst.expectByte(word[7:0]);
        end
        writeMsg(8'(linkPkg::READ_MEM), len, nops);
        while (checkerInst.pendingBytes() != 0) begin
            shiftByte(8'h00);
        end
        maybeGap();
    endtask

    task automatic unknownMsg();
        randomizePayload();
        writeMsg(8'(3 + $urandom % 253), int'($urandom % 7), 0);
        maybeGap();
    endtask

    // A closing read flushes the handler so the LEDs are settled
    task automatic finishTest(input string name);
        readMem(2, 0);
        checkerInst.endTest(name, expLed);
    endtask

    initial begin
        #(WatchdogCycles * 2 * ClkHalf);
        $display("Timeout: the DUT did not deliver its replies within %0d cycles",
            WatchdogCycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        cs = 1'b0;
        di = 1'b0;
        rstN = 1'b0;
        expLed = 4'd0;
        void'($urandom(Seed));
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        // Handler fills one memory word per cycle before taking messages
        repeat (`MEM_WORDS + 4) @(posedge clk);

        repeat (8) setLed(1 + int'($urandom % 3), 0);
        finishTest("setLed");

        repeat (8) readMem(2, 0);
        finishTest("readMem");

        repeat (10) begin
            if ($urandom % 2 == 0) begin
                setLed(6 + int'($urandom % 4), int'($urandom % 4));
            end else begin
                readMem(6 + int'($urandom % 4), int'($urandom % 4));
            end
        end
        finishTest("nopsAndLongPayloads");

        // Cut messages come after a full SetLed so a stray LED write would show
        repeat (3) begin
            setLed(1, 0);
            randomizePayload();
            cutMsg(8'(linkPkg::SET_LED), 1, 17 + int'($urandom % 7));
            randomizePayload();
            cutMsg(8'(linkPkg::READ_MEM), 2, 25 + int'($urandom % 7));
            readMem(2, 0);
        end
        finishTest("csDrop");

        repeat (6) unknownMsg();
        finishTest("unknownTypes");

        checkerInst.closeRun();
        if (checkerInst.errorTotal() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- test/debugChecker.sv
`timescale 1ns/1ps

module debugChecker (
    input logic       clk,
    input logic       rstN,
    input logic       cs,
    input logic       dout,
    input logic [3:0] led
);
    // Reply bytes the host expects, in arrival order
    logic [7:0] expQ [$];
    logic [7:0] shiftIn = 8'd0;
    int bitCount = 0;
    int remaining = 0;
    linkPkg::rxStateE rxState = linkPkg::RX_WAIT_TYPE;

    int byteChecks = 0;
    int byteErrors = 0;
    int errorMark = 0;
    int ledErrors = 0;
    int missing = 0;
    int testsPassed = 0;
    int testsFailed = 0;

    task automatic expectByte(input logic [7:0] b);
        expQ.push_back(b);
    endtask

    function automatic int pendingBytes();
        return expQ.size();
    endfunction

    function automatic int errorTotal();
        return byteErrors + ledErrors + missing;
    endfunction

    task automatic compareByte(input logic [7:0] got, input string what);
        logic [7:0] want;
        byteChecks++;
        if (expQ.size() == 0) begin
            byteErrors++;
            $display("Fail at %0d ns: unexpected %s byte %h from the DUT", $time, what, got);
        end else begin
            want = expQ.pop_front();
            if (want != got) begin
                byteErrors++;
                $display("Fail at %0d ns: %s byte expected %h got %h", $time, what, want, got);
            end
        end
    endtask

    // Host side message decode that skips zero fill bytes between messages
    task automatic decodeByte(input logic [7:0] b);
        case (rxState)
            linkPkg::RX_WAIT_TYPE: begin
                if (b != 8'(linkPkg::NOP)) begin
                    compareByte(b, "type");
                    rxState = linkPkg::RX_WAIT_LEN;
                end
            end
            linkPkg::RX_WAIT_LEN: begin
                compareByte(b, "length");
                remaining = int'(b);
                rxState = (b == 8'd0) ? linkPkg::RX_WAIT_TYPE : linkPkg::RX_PAYLOAD;
            end
            default: begin
                compareByte(b, "payload");
                remaining--;
                if (remaining == 0) begin
                    rxState = linkPkg::RX_WAIT_TYPE;
                end
            end
        endcase
    endtask

    // ==========================================================================
    // Frame alignment restarts with every cs rise
    // ==========================================================================
    always @(posedge clk) begin
        if (!rstN || !cs) begin
            bitCount = 0;
        end else begin
            shiftIn = {shiftIn[6:0], dout};
            bitCount++;
            if (bitCount == 8) begin
                bitCount = 0;
                decodeByte(shiftIn);
            end
        end
    end

    task automatic endTest(input string name, input logic [3:0] expLed);
        int errs;
        errs = byteErrors - errorMark;
        errorMark = byteErrors;
        if (led !== expLed) begin
            $display("Fail at %0d ns: led expected %h got %h", $time, expLed, led);
            ledErrors++;
            errs++;
        end
        if (errs == 0) begin
            testsPassed++;
            $display("Test %s: passed", name);
        end else begin
            testsFailed++;
            $display("Test %s: failed with %0d errors", name, errs);
        end
    endtask

    task automatic closeRun();
        if (expQ.size() != 0) begin
            missing = expQ.size();
            $display("Expected reply bytes never arrived, %0d still missing", missing);
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d, byte checks: %0d, errors: %0d",
            testsPassed + testsFailed, testsPassed, testsFailed, byteChecks, errorTotal());
    endtask

endmodule

//--- design/debugTop.sv
`timescale 1ns/1ps
`include "debugLink_settings.svh"

module debugTop (
    input  logic       clk,
    input  logic       rstN,
    input  logic       cs,
    input  logic       di,
    output logic       dout,
    output logic [3:0] led
);
    // Inbound message queue
    logic inPush;
    logic [`MSG_WIDTH-1:0] inData;
    logic inPop;
    logic [`MSG_WIDTH-1:0] inHead;
    logic inNotEmpty;
    logic inNotFull;

    // Outbound byte queue
    logic outPush;
    logic [7:0] outData;
    logic outPop;
    logic [7:0] outHead;
    logic outNotEmpty;
    logic outNotFull;

    // Handler to sender
    linkPkg::msgTypeE replyType;
    logic [7:0] replyLen;
    logic [7:0] payloadByte;
    logic payloadNext;
    logic replyDone;

    // ============================================================================
    // Serial link
    // ============================================================================
    serialRx serialRx_inst (
        .clk(clk), .rstN(rstN), .cs(cs), .di(di),
        .msgReady(inNotFull), .msgPush(inPush), .msgData(inData)
    );

    msgQueue #(.Width(`MSG_WIDTH), .Depth(`IN_QUEUE_DEPTH)) inQueue_inst (
        .clk(clk), .rstN(rstN), .push(inPush), .pushData(inData), .pop(inPop),
        .head(inHead), .notEmpty(inNotEmpty), .notFull(inNotFull)
    );

    msgQueue #(.Width(8), .Depth(`OUT_QUEUE_DEPTH)) outQueue_inst (
        .clk(clk), .rstN(rstN), .push(outPush), .pushData(outData), .pop(outPop),
        .head(outHead), .notEmpty(outNotEmpty), .notFull(outNotFull)
    );

    serialTx serialTx_inst (
        .clk(clk), .rstN(rstN), .cs(cs), .byteHead(outHead),
        .byteAvail(outNotEmpty), .bytePop(outPop), .dout(dout)
    );

    // ============================================================================
    // Command engine
    // ============================================================================
    msgSender msgSender_inst (
        .clk(clk), .rstN(rstN), .replyType(replyType), .replyLen(replyLen),
        .payloadByte(payloadByte), .payloadNext(payloadNext), .replyDone(replyDone),
        .outPush(outPush), .outData(outData), .outReady(outNotFull)
    );

    cmdHandler cmdHandler_inst (
        .clk(clk), .rstN(rstN), .msgHead(inHead), .msgAvail(inNotEmpty), .msgPop(inPop),
        .replyType(replyType), .replyLen(replyLen), .payloadByte(payloadByte),
        .payloadNext(payloadNext), .replyDone(replyDone), .led(led)
    );

endmodule

//--- design/cmdHandler.sv
`timescale 1ns/1ps
`include "debugLink_settings.svh"

module cmdHandler (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [`MSG_WIDTH-1:0] msgHead,
    input  logic                  msgAvail,
    output logic                  msgPop,
    output linkPkg::msgTypeE      replyType,
    output logic [7:0]            replyLen,
    output logic [7:0]            payloadByte,
    input  logic                  payloadNext,
    input  logic                  replyDone,
    output logic [3:0]            led
);
    logic [15:0] mem [`MEM_WORDS];
    logic [`MEM_ADDR_W-1:0] fillAddr;
    logic [`MEM_ADDR_W-1:0] rdAddr;
    logic hiByte;
    linkPkg::msgTypeE cmdType;
    logic [8*`MSG_MAX_PAYLOAD-1:0] cmdPayload;
    logic [6:0] readCount;
    cmdPkg::handlerStateE state;

    assign msgPop = (state == cmdPkg::H_FETCH) && msgAvail;

    // Word count from payload byte 1 is capped so the length fits a byte
    assign readCount = (cmdPayload[15:8] > 8'd127) ? 7'd127 : cmdPayload[14:8];

    // ============================================================================
    // Memory and reply byte
    // ============================================================================
    always_ff @(posedge clk) begin
        if (state == cmdPkg::H_FILL) begin
            mem[fillAddr] <= 16'(fillAddr);
        end
        if (payloadNext) begin
            payloadByte <= hiByte ? mem[rdAddr][15:8] : mem[rdAddr][7:0];
        end
    end

    // ============================================================================
    // Control
    // ============================================================================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= cmdPkg::H_FILL;
            fillAddr <= '0;
            rdAddr <= '0;
            hiByte <= 1'b1;
            replyType <= linkPkg::NOP;
            led <= 4'd0;
        end else begin
            case (state)
                cmdPkg::H_FILL: begin
                    fillAddr <= fillAddr + 1'b1;
                    if (fillAddr == `MEM_ADDR_W'(`MEM_WORDS - 1)) begin
                        state <= cmdPkg::H_FETCH;
                    end
                end
                cmdPkg::H_FETCH: begin
                    if (msgAvail) begin
                        cmdType <= linkPkg::msgTypeE'(msgHead[7:0]);
                        cmdPayload <= msgHead[`MSG_WIDTH-1:16];
                        state <= cmdPkg::H_DISPATCH;
                    end
                end
                cmdPkg::H_DISPATCH: begin
                    state <= cmdPkg::H_FETCH;
                    case (cmdType)
                        linkPkg::SET_LED: led <= cmdPayload[3:0];
                        linkPkg::READ_MEM: begin
                            rdAddr <= cmdPayload[`MEM_ADDR_W-1:0];
                            hiByte <= 1'b1;
                            if (readCount != 7'd0) begin
                                replyType <= linkPkg::READ_MEM;
                                replyLen <= {readCount, 1'b0};
                                state <= cmdPkg::H_REPLY;
                            end
                        end
                        default: ;
                    endcase
                end
                cmdPkg::H_REPLY: begin
                    // High byte first, then step to the next word
                    if (payloadNext) begin
                        hiByte <= !hiByte;
                        if (!hiByte) begin
                            rdAddr <= rdAddr + 1'b1;
                        end
                    end
                    if (replyDone) begin
                        replyType <= linkPkg::NOP;
                        state <= cmdPkg::H_FETCH;
                    end
                end
                default: state <= cmdPkg::H_FETCH;
            endcase
        end
    end

    // Sender only asks for bytes while a reply is open
    nextInReply: assert property (@(posedge clk) disable iff (!rstN)
        payloadNext |-> state == cmdPkg::H_REPLY);

endmodule

//--- design/msgSender.sv
`timescale 1ns/1ps

module msgSender (
    input  logic             clk,
    input  logic             rstN,
    input  linkPkg::msgTypeE replyType,
    input  logic [7:0]       replyLen,
    input  logic [7:0]       payloadByte,
    output logic             payloadNext,
    output logic             replyDone,
    output logic             outPush,
    output logic [7:0]       outData,
    input  logic             outReady
);
    linkPkg::txMsgStateE state;
    logic [7:0] byteCount;
    logic canWrite;

    // One idle cycle between pushes keeps outReady current
    assign canWrite = outReady && !outPush;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= linkPkg::TX_IDLE;
            outPush <= 1'b0;
            payloadNext <= 1'b0;
            replyDone <= 1'b0;
            byteCount <= 8'd0;
        end else begin
            outPush <= 1'b0;
            payloadNext <= 1'b0;
            replyDone <= 1'b0;
            case (state)
                linkPkg::TX_IDLE: begin
                    // A push still in flight here was the last byte of a reply
                    replyDone <= outPush;
                    if (replyType != linkPkg::NOP && !replyDone && !outPush) begin
                        state <= linkPkg::TX_TYPE;
                    end
                end
                linkPkg::TX_TYPE: begin
                    if (canWrite) begin
                        outPush <= 1'b1;
                        outData <= replyType;
                        state <= linkPkg::TX_LENGTH;
                    end
                end
                linkPkg::TX_LENGTH: begin
                    if (canWrite) begin
                        outPush <= 1'b1;
                        outData <= replyLen;
                        byteCount <= replyLen;
                        state <= (replyLen == 8'd0) ? linkPkg::TX_IDLE : linkPkg::TX_REQ_BYTE;
                    end
                end
                linkPkg::TX_REQ_BYTE: begin
                    payloadNext <= 1'b1;
                    state <= linkPkg::TX_WRITE_BYTE;
                end
                linkPkg::TX_WRITE_BYTE: begin
                    // Handler needs the cycle after payloadNext to present the byte
                    if (canWrite && !payloadNext) begin
                        outPush <= 1'b1;
                        outData <= payloadByte;
                        byteCount <= byteCount - 8'd1;
                        state <= (byteCount == 8'd1) ? linkPkg::TX_IDLE : linkPkg::TX_REQ_BYTE;
                    end
                end
                default: state <= linkPkg::TX_IDLE;
            endcase
        end
    end

    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN) outPush |-> outReady);

endmodule

//--- design/serialTx.sv
`timescale 1ns/1ps

module serialTx (
    input  logic       clk,
    input  logic       rstN,
    input  logic       cs,
    input  logic [7:0] byteHead,
    input  logic       byteAvail,
    output logic       bytePop,
    output logic       dout
);
    // Low bit is the sentinel and is never shifted out
    logic [8:0] shiftReg;
    logic lastBit;

    // Sentinel at bit 7 means the eighth bit of the frame is on dout
    assign lastBit = (shiftReg[7:0] == 8'h80);
    assign bytePop = cs && lastBit && byteAvail;
    assign dout = shiftReg[8];

    always_ff @(posedge clk) begin
        if (!rstN || !cs) begin
            // Zero byte with sentinel so the first frame is empty
            shiftReg <= 9'd1;
        end else if (lastBit) begin
            shiftReg <= {byteAvail ? byteHead : 8'd0, 1'b1};
        end else begin
            shiftReg <= {shiftReg[7:0], 1'b0};
        end
    end

endmodule

//--- design/serialRx.sv
`timescale 1ns/1ps
`include "debugLink_settings.svh"

module serialRx (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  cs,
    input  logic                  di,
    input  logic                  msgReady,
    output logic                  msgPush,
    output logic [`MSG_WIDTH-1:0] msgData
);
    logic [8:0] shiftReg;
    logic [7:0] payCount;
    logic byteReady;
    logic [7:0] rxByte;
    linkPkg::rxStateE state;

    // Sentinel reaches bit 8 once eight data bits are in
    assign byteReady = shiftReg[8];
    assign rxByte = shiftReg[7:0];

    always_ff @(posedge clk) begin
        if (!rstN || !cs) begin
            shiftReg <= 9'd1;
            payCount <= 8'd0;
            msgPush <= 1'b0;
            state <= linkPkg::RX_WAIT_TYPE;
        end else begin
            msgPush <= 1'b0;
            if (byteReady) begin
                shiftReg <= {7'd0, 1'b1, di};
            end else begin
                shiftReg <= {shiftReg[7:0], di};
            end

            if (byteReady) begin
                case (state)
                    // Nop bytes keep us here so a message may start on any byte
                    linkPkg::RX_WAIT_TYPE: begin
                        if (rxByte != 8'(linkPkg::NOP)) begin
                            msgData <= {{(`MSG_WIDTH - 8){1'b0}}, rxByte};
                            state <= linkPkg::RX_WAIT_LEN;
                        end
                    end
                    linkPkg::RX_WAIT_LEN: begin
                        msgData[15:8] <= rxByte;
                        payCount <= 8'd0;
                        if (rxByte == 8'd0) begin
                            msgPush <= msgReady;
                            state <= linkPkg::RX_WAIT_TYPE;
                        end else begin
                            state <= linkPkg::RX_PAYLOAD;
                        end
                    end
                    linkPkg::RX_PAYLOAD: begin
                        // Bytes past the stored ones are only counted
                        if (payCount < `MSG_MAX_PAYLOAD) begin
                            msgData[(int'(payCount) + 2) * 8 +: 8] <= rxByte;
                        end
                        payCount <= payCount + 8'd1;
                        if (payCount + 8'd1 == msgData[15:8]) begin
                            msgPush <= msgReady;
                            state <= linkPkg::RX_WAIT_TYPE;
                        end
                    end
                    default: state <= linkPkg::RX_WAIT_TYPE;
                endcase
            end
        end
    end

endmodule

//--- design/msgQueue.sv
`timescale 1ns/1ps

module msgQueue #(
    parameter int Width = 8,
    parameter int Depth = 4
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             push,
    input  logic [Width-1:0] pushData,
    input  logic             pop,
    output logic [Width-1:0] head,
    output logic             notEmpty,
    output logic             notFull
);
    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;

    logic [Width-1:0] store [Depth];
    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] wrPtr;
    logic [PtrW:0] fill;
    logic doPush;
    logic doPop;

    assign doPush = push && notFull;
    assign doPop = pop && notEmpty;
    assign notEmpty = (fill != '0);
    assign notFull = (fill != (PtrW + 1)'(Depth));

    // First word falls through
    assign head = store[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            store[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            fill <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Producers and consumers honor the flags
    pushWhenFull: assert property (@(posedge clk) disable iff (!rstN) push |-> notFull);
    popWhenEmpty: assert property (@(posedge clk) disable iff (!rstN) pop |-> notEmpty);

endmodule

//--- design/cmdPkg.sv
package cmdPkg;

    // Command handler sequencing
    // Fill runs once after reset, then fetch and dispatch loop
    typedef enum logic [1:0] {
        H_FILL,
        H_FETCH,
        H_DISPATCH,
        H_REPLY
    } handlerStateE;

endpackage

//--- design/linkPkg.sv
package linkPkg;

    // Message type byte as seen on the serial link
    typedef enum logic [7:0] {
        NOP      = 8'd0,
        SET_LED  = 8'd1,
        READ_MEM = 8'd2
    } msgTypeE;

    // Receive side message assembly
    typedef enum logic [1:0] {
        RX_WAIT_TYPE,
        RX_WAIT_LEN,
        RX_PAYLOAD
    } rxStateE;

    // Reply serializer into the outbound byte queue
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_TYPE,
        TX_LENGTH,
        TX_REQ_BYTE,
        TX_WRITE_BYTE
    } txMsgStateE;

endpackage

//--- include/debugLink_settings.svh
`ifndef DEBUGLINK_SETTINGS_SVH
`define DEBUGLINK_SETTINGS_SVH

// Stored payload bytes per message
`define MSG_MAX_PAYLOAD 5
// Type byte, length byte and stored payload
`define MSG_WIDTH (8 * (2 + `MSG_MAX_PAYLOAD))

// Inbound depth counts messages, outbound depth counts bytes
`define IN_QUEUE_DEPTH 4
`define OUT_QUEUE_DEPTH 4

// On-chip memory of 16-bit words
`define MEM_WORDS 128
`define MEM_ADDR_W 7

`endif
